//--- tb.f
+incdir+test
design/cic_cfg_pkg.sv
design/rx_types_pkg.sv
design/cic_integrator.sv
design/cic_comb.sv
design/varcic.sv
design/sample_arbiter.sv
design/rx_top.sv
test/tb_top.sv

//--- Makefile
# Verilator build, run, lint and clean for the receiver testbench

SIM        ?= verilator
TOP        ?= tb_top
FLIST      ?= tb.f
BUILD      ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wno-fatal
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

# pass or fail comes from the log, not the exit status of tee
run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- test/tb_model.svh
// CIC reference model and LFSR random source, included inside the receiver testbench module
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ---------------------------------------------------------------------------
// random source
// ---------------------------------------------------------------------------

logic [31:0] lfsr_state;

// galois lfsr, right shifting, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return r;
endfunction

// ---------------------------------------------------------------------------
// per-channel cic state, sample level
// ---------------------------------------------------------------------------

logic signed [acc_width-1:0] integ_acc [num_chan][cic_stages];
logic signed [acc_width-1:0] comb_reg  [num_chan][cic_stages];
logic signed [acc_width-1:0] comb_dly  [num_chan][cic_stages];
int                          in_count  [num_chan];
// decimated samples still owed by the dut
logic [out_width-1:0]        exp_q     [num_chan][$];

// everything back to the post-reset state
function automatic void model_clear();
  for (int c = 0; c < num_chan; c++)
  begin
    for (int s = 0; s < cic_stages; s++)
    begin
      integ_acc[c][s] = '0;
      comb_reg[c][s]  = '0;
      comb_dly[c][s]  = '0;
    end
    in_count[c] = 0;
    exp_q[c].delete();
  end
endfunction

// one adc sample into channel ch
function automatic void cic_step(input int ch, input dec_code_t code,
                                 input logic signed [in_width-1:0] x);
  int                          factor;
  int                          growth;
  logic signed [acc_width-1:0] stage_in;
  logic signed [acc_width-1:0] full_res;
  logic [out_width-1:0]        kept;
  // log2 of the factor is code+1
  factor = 1 << (int'(code) + 1);
  growth = cic_stages * (int'(code) + 1);
  // last stage first, so each stage adds the older upstream value
  for (int s = cic_stages - 1; s > 0; s--)
    integ_acc[ch][s] = integ_acc[ch][s] + integ_acc[ch][s-1];
  integ_acc[ch][0] = integ_acc[ch][0] + acc_width'(x);
  in_count[ch]++;
  if (in_count[ch] == factor)
  begin
    in_count[ch] = 0;
    // comb chain, same pipelining as the integrators
    for (int s = cic_stages - 1; s >= 0; s--)
    begin
      stage_in        = (s == 0) ? integ_acc[ch][cic_stages-1] : comb_reg[ch][s-1];
      comb_reg[ch][s] = stage_in - comb_dly[ch][s];
      comb_dly[ch][s] = stage_in;
    end
    // kept slice plus the bit just below, wraps at out_width
    full_res = comb_reg[ch][cic_stages-1];
    kept     = full_res[growth +: out_width];
    exp_q[ch].push_back(kept + out_width'(full_res[growth-1]));
  end
endfunction

`endif

//--- test/tb_top.sv
// Self-checking random testbench for the two-channel receiver, compiled from tb.f by the Makefile
`timescale 1ns/1ps

module tb_top
  import cic_cfg_pkg::*, rx_types_pkg::*;
();

  // ---------------------------------------------------------------------------
  // test lengths and run budget
  // ---------------------------------------------------------------------------

  localparam int cyc_ns  = 8;
  localparam int slack   = 200;
  localparam int n_fixed = 128;
  localparam int n_mixed = 64;
  localparam int n_count = 64;
  localparam int n_full  = 192;
  localparam int n_stall = 16;
  // strobe gap 2, except 4 in the four random back-pressure runs
  localparam int budget_cycles = slack + (n_fixed * 2 + slack) + 4 * (n_mixed * 4 + slack)
                               + (n_count * 2 + slack) + (n_full * 2 + slack)
                               + (n_stall * 2 + slack);

  localparam int ready_high = 0;
  localparam int ready_low  = 1;
  localparam int ready_rand = 2;

  localparam logic signed [in_width-1:0] full_pos = {1'b0, {(in_width-1){1'b1}}};
  localparam logic signed [in_width-1:0] full_neg = {1'b1, {(in_width-1){1'b0}}};

  logic                       clock;
  logic                       rst_all;
  logic                       adc_strobe;
  logic signed [in_width-1:0] adc_data;
  dec_code_t                  dec_sel [num_chan];
  logic                       out_valid;
  logic                       out_ready;
  rx_word_t                   out_word;
  logic [num_chan-1:0]        overflow;

  int   ready_mode    = ready_high;
  int   err_count     = 0;
  int   word_total    = 0;
  int   tests_run     = 0;
  int   tests_failed  = 0;
  int   errs_at_start = 0;
  int   words_at_start = 0;
  int   words_seen [num_chan];
  logic resync_ch0    = 1'b0;

  `include "tb_model.svh"

  rx_top u_rx_top (
    .clock      (clock),
    .rst_all    (rst_all),
    .adc_strobe (adc_strobe),
    .adc_data   (adc_data),
    .dec_sel    (dec_sel),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_word   (out_word),
    .overflow   (overflow)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // watchdog
  initial
  begin
    #(budget_cycles * cyc_ns);
    $display("watchdog expired after %0d cycles, test sequence never finished", budget_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ---------------------------------------------------------------------------
  // scoreboard, one check per accepted word
  // ---------------------------------------------------------------------------

  always @(posedge clock)
  begin
    logic [out_width-1:0] exp_val;
    int                   ch;
    if (!rst_all && out_valid && out_ready)
    begin
      ch = int'(out_word.chan);
      words_seen[ch]++;
      word_total++;
      assert (exp_q[ch].size() != 0)
      else
      begin
        $display("channel %0d delivered a word while no sample was expected", ch);
        err_count++;
      end
      if (exp_q[ch].size() != 0)
      begin
        exp_val = exp_q[ch].pop_front();
        assert (out_word.sample === exp_val)
        else
        begin
          $display("FAIL out_word.sample ch%0d expected %05h actual %05h",
                   ch, exp_val, out_word.sample);
          err_count++;
        end
        // after a stall, the rest of ch0's queue was dropped by the dut
        if (ch == 0 && resync_ch0)
        begin
          exp_q[0].delete();
          resync_ch0 = 1'b0;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  // low one cycle in four, never twice running
  function automatic logic next_ready();
    if (ready_mode == ready_high)
      return 1'b1;
    if (ready_mode == ready_low)
      return 1'b0;
    if (!out_ready)
      return 1'b1;
    return rand_bits(2) != 0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
    else
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic apply_reset(input dec_code_t code0, input dec_code_t code1);
    @(negedge clock);
    rst_all    = 1'b1;
    adc_strobe = 1'b0;
    out_ready  = 1'b0;
    dec_sel[0] = code0;
    dec_sel[1] = code1;
    repeat (3) @(negedge clock);
    rst_all    = 1'b0;
    model_clear();
    words_seen = '{default: 0};
    resync_ch0 = 1'b0;
  endtask

  // n_in strobes, one every gap cycles
  task automatic feed(input int n_in, input int gap, input bit full_scale);
    logic signed [in_width-1:0] x;
    for (int i = 0; i < n_in; i++)
    begin
      // full scale flips sign every 48 strobes
      if (full_scale)
        x = ((i / 48) % 2 == 0) ? full_pos : full_neg;
      else
        x = in_width'(rand_bits(in_width));
      @(negedge clock);
      adc_strobe = 1'b1;
      adc_data   = x;
      out_ready  = next_ready();
      for (int c = 0; c < num_chan; c++)
        cic_step(c, dec_sel[c], x);
      repeat (gap - 1)
      begin
        @(negedge clock);
        adc_strobe = 1'b0;
        out_ready  = next_ready();
      end
    end
  endtask

  // wait for every expected word, then a few quiet cycles
  task automatic drain(input int max_cycles);
    int waited;
    waited = 0;
    while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && waited < max_cycles)
    begin
      @(negedge clock);
      out_ready = next_ready();
      waited++;
    end
    repeat (8)
    begin
      @(negedge clock);
      out_ready = next_ready();
    end
    assert (exp_q[0].size() == 0 && exp_q[1].size() == 0)
    else
    begin
      $display("drain timed out, %0d ch0 and %0d ch1 samples never arrived",
               exp_q[0].size(), exp_q[1].size());
      err_count++;
    end
  endtask

  task automatic begin_test();
    errs_at_start  = err_count;
    words_at_start = word_total;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_count - errs_at_start;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("test %0d %s: %0d words, %0d errors",
             tests_run, name, word_total - words_at_start, errs);
  endtask

  // ---------------------------------------------------------------------------
  // test sequence
  // ---------------------------------------------------------------------------

  initial
  begin
    int seen0;
    int seen1;
    lfsr_state = 32'h2fbb;
    rst_all    = 1'b1;
    adc_strobe = 1'b0;
    adc_data   = '0;
    out_ready  = 1'b0;
    dec_sel[0] = 2'd0;
    dec_sel[1] = 2'd0;
    words_seen = '{default: 0};
    seen0      = 0;
    seen1      = 0;

    // idle outputs straight after reset
    begin_test();
    ready_mode = ready_high;
    apply_reset(2'd0, 2'd0);
    repeat (8)
    begin
      @(negedge clock);
      out_ready = next_ready();
      check_value("out_valid", out_valid, 0);
      check_value("overflow", overflow, 0);
    end
    end_test("reset idle");

    // factor 2 against factor 16, no back-pressure
    begin_test();
    apply_reset(2'd0, 2'd3);
    feed(n_fixed, 2, 1'b0);
    drain(slack);
    check_value("overflow", overflow, 0);
    end_test("fixed rates");

    // every ch0 code, ch1 one code ahead, random ready
    begin_test();
    ready_mode = ready_rand;
    for (int k = 0; k < 4; k++)
    begin
      apply_reset(dec_code_t'(k), dec_code_t'(k + 1));
      feed(n_mixed, 4, 1'b0);
      drain(slack);
      check_value("overflow", overflow, 0);
      seen0 += words_seen[0];
      seen1 += words_seen[1];
    end
    assert (seen0 > 0 && seen1 > 0)
    else
    begin
      $display("one channel never showed up on the output bus");
      err_count++;
    end
    end_test("mixed rates");

    // word counts, factors 4 and 8
    begin_test();
    ready_mode = ready_high;
    apply_reset(2'd1, 2'd2);
    feed(n_count, 2, 1'b0);
    drain(slack);
    check_value("ch0 word count", words_seen[0], n_count / 4);
    check_value("ch1 word count", words_seen[1], n_count / 8);
    end_test("word count");

    // full-scale steps through the rounding
    begin_test();
    apply_reset(2'd3, 2'd1);
    feed(n_full, 2, 1'b1);
    drain(slack);
    check_value("overflow", overflow, 0);
    end_test("full scale");

    // bus stalled until ch0 overflows
    begin_test();
    ready_mode = ready_low;
    apply_reset(2'd0, 2'd3);
    feed(n_stall, 2, 1'b0);
    repeat (10) @(negedge clock);
    check_value("overflow", overflow, 1);
    resync_ch0 = 1'b1;
    ready_mode = ready_high;
    drain(slack);
    check_value("ch0 word count", words_seen[0], 1);
    check_value("ch1 word count", words_seen[1], 1);
    end_test("stall overflow");

    $display("summary: %0d tests, %0d failed, %0d words checked, %0d errors",
             tests_run, tests_failed, word_total, err_count);
    if (err_count == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- design/rx_top.sv
// Two-channel receiver front end, two CIC decimators merged by the sample arbiter
`timescale 1ns/1ps

module rx_top
  import cic_cfg_pkg::*, rx_types_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst_all,
  input  logic                       adc_strobe,
  input  logic signed [in_width-1:0] adc_data,
  input  dec_code_t                  dec_sel [num_chan],
  output logic                       out_valid,
  input  logic                       out_ready,
  output rx_word_t                   out_word,
  output logic [num_chan-1:0]        overflow
);

  // per-channel decimator outputs
  logic [num_chan-1:0] dec_valid;
  dec_sample_t         dec_sample [num_chan];

  // --------------------------------------------------------------------------
  // decimators, shared adc stream
  // --------------------------------------------------------------------------

  varcic u_cic0 (
    .clock      (clock),
    .rst_all    (rst_all),
    .in_strobe  (adc_strobe),
    .in_data    (adc_data),
    .dec_sel    (dec_sel[0]),
    .dec_valid  (dec_valid[0]),
    .dec_sample (dec_sample[0])
  );

  varcic u_cic1 (
    .clock      (clock),
    .rst_all    (rst_all),
    .in_strobe  (adc_strobe),
    .in_data    (adc_data),
    .dec_sel    (dec_sel[1]),
    .dec_valid  (dec_valid[1]),
    .dec_sample (dec_sample[1])
  );

  // --------------------------------------------------------------------------
  // merge onto output bus
  // --------------------------------------------------------------------------

  sample_arbiter u_arb (
    .clock     (clock),
    .rst_all   (rst_all),
    .in_valid  (dec_valid),
    .in_sample (dec_sample),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word),
    .overflow  (overflow)
  );

endmodule

//--- design/sample_arbiter.sv
// Round-robin merge of per-channel decimated samples onto one valid/ready bus, with overflow flags
`timescale 1ns/1ps

module sample_arbiter
  import rx_types_pkg::*;
(
  input  logic                clock,
  input  logic                rst_all,
  input  logic [num_chan-1:0] in_valid,
  input  dec_sample_t         in_sample [num_chan],
  output logic                out_valid,
  input  logic                out_ready,
  output rx_word_t            out_word,
  output logic [num_chan-1:0] overflow
);

  // --------------------------------------------------------------------------
  // hold registers
  // --------------------------------------------------------------------------

  dec_sample_t         hold [num_chan];
  logic [num_chan-1:0] full;
  // hold emptied by a transfer this cycle
  logic [num_chan-1:0] drain;
  // full and staying full past this edge
  logic [num_chan-1:0] hold_busy;
  logic                xfer;

  assign xfer = out_valid && out_ready;

  always_comb
  begin
    for (int c = 0; c < num_chan; c++)
    begin
      drain[c]     = xfer && (out_word.chan == chan_t'(c));
      hold_busy[c] = full[c] && !drain[c];
    end
  end

  // new sample lands only in a free hold
  // a busy hold keeps its older sample
  always_ff @(posedge clock)
  begin
    for (int c = 0; c < num_chan; c++)
    begin
      if (in_valid[c] && !hold_busy[c])
      begin
        hold[c] <= in_sample[c];
      end
    end
  end

  // --------------------------------------------------------------------------
  // round-robin pick
  // --------------------------------------------------------------------------

  chan_t last_grant;
  chan_t pick;
  logic  pick_any;

  // scan starts one past the last grant
  always_comb
  begin : rr_pick
    chan_t cand;
    pick     = last_grant;
    pick_any = 1'b0;
    for (int i = 1; i <= num_chan; i++)
    begin
      cand = chan_t'((int'(last_grant) + i) % num_chan);
      if (!pick_any && full[cand])
      begin
        pick     = cand;
        pick_any = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // control state and output bus
  // --------------------------------------------------------------------------

  always_ff @(posedge clock)
  begin
    if (rst_all)
    begin
      full       <= '0;
      overflow   <= '0;
      out_valid  <= 1'b0;
      last_grant <= chan_t'(num_chan - 1);
    end
    else
    begin
      for (int c = 0; c < num_chan; c++)
      begin
        if (in_valid[c] && !hold_busy[c])
        begin
          full[c] <= 1'b1;
        end
        else if (drain[c])
        begin
          full[c] <= 1'b0;
        end
        // sticky until reset
        if (in_valid[c] && hold_busy[c])
        begin
          overflow[c] <= 1'b1;
        end
      end

      // one word in flight, a new offer only while the bus is idle
      if (xfer)
      begin
        out_valid <= 1'b0;
      end
      else if (!out_valid && pick_any)
      begin
        out_valid  <= 1'b1;
        last_grant <= pick;
      end
    end
  end

  // word payload, frozen while offered
  always_ff @(posedge clock)
  begin
    if (!out_valid && pick_any)
    begin
      out_word.chan   <= pick;
      out_word.sample <= hold[pick].sample;
    end
  end

  // stalled word must not change
  a_stall_stable : assert property (
    @(posedge clock) disable iff (rst_all)
    out_valid && !out_ready |=> out_valid && $stable(out_word)
  ) else $error("out_word changed while stalled");

  // bus idle right after reset
  a_reset_idle : assert property (
    @(posedge clock) rst_all |=> !out_valid
  ) else $error("out_valid high after reset");

endmodule

//--- design/varcic.sv
// Variable-rate five-stage CIC decimator, factor picked by dec_sel; one per receiver channel
`timescale 1ns/1ps

module varcic
  import cic_cfg_pkg::*, rx_types_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst_all,
  input  logic                       in_strobe,
  input  logic signed [in_width-1:0] in_data,
  input  dec_code_t                  dec_sel,
  output logic                       dec_valid,
  output dec_sample_t                dec_sample
);

  // --------------------------------------------------------------------------
  // rate control
  // --------------------------------------------------------------------------

  logic [cnt_width-1:0] sample_cnt;
  logic [cnt_width-1:0] last_cnt;
  // high for one cycle after the D-th input strobe
  logic                 out_strobe;
  // combs just updated, rounding captures next edge
  logic                 comb_done;

  assign last_cnt = cnt_width'(dec_factor(dec_sel) - 1);

  always_ff @(posedge clock)
  begin
    if (rst_all)
    begin
      sample_cnt <= '0;
      out_strobe <= 1'b0;
    end
    else if (in_strobe)
    begin
      // wrap on the D-th sample and fire the output strobe
      if (sample_cnt == last_cnt)
      begin
        sample_cnt <= '0;
        out_strobe <= 1'b1;
      end
      else
      begin
        sample_cnt <= sample_cnt + 1'b1;
        out_strobe <= 1'b0;
      end
    end
    else
    begin
      out_strobe <= 1'b0;
    end
  end

  // two-stage valid pipe behind out_strobe
  // comb update edge, then rounding edge
  always_ff @(posedge clock)
  begin
    if (rst_all)
    begin
      comb_done <= 1'b0;
      dec_valid <= 1'b0;
    end
    else
    begin
      comb_done <= out_strobe;
      dec_valid <= comb_done;
    end
  end

  // --------------------------------------------------------------------------
  // integrator and comb chains
  // --------------------------------------------------------------------------

  logic signed [acc_width-1:0] integ_data [cic_stages+1];
  logic signed [acc_width-1:0] comb_data  [cic_stages+1];

  // sign extend adc sample to accumulator width
  assign integ_data[0] = {{(acc_width-in_width){in_data[in_width-1]}}, in_data};
  // last integrator feeds the comb section
  assign comb_data[0]  = integ_data[cic_stages];

  for (genvar i = 0; i < cic_stages; i++)
  begin : g_stage
    // input rate
    cic_integrator u_integ (
      .clock    (clock),
      .rst_all  (rst_all),
      .strobe   (in_strobe),
      .in_data  (integ_data[i]),
      .out_data (integ_data[i+1])
    );

    // output rate
    cic_comb u_comb (
      .clock    (clock),
      .rst_all  (rst_all),
      .strobe   (out_strobe),
      .in_data  (comb_data[i]),
      .out_data (comb_data[i+1])
    );
  end

  // --------------------------------------------------------------------------
  // output rounding
  // --------------------------------------------------------------------------

  // comb result shifted so the rounding bit lands on bit 0
  logic signed [acc_width-1:0] round_src;

  assign round_src = comb_data[cic_stages] >>> round_lsb(dec_sel);

  // kept slice plus the bit below it, wraps at out_width
  always_ff @(posedge clock)
  begin
    if (comb_done)
    begin
      dec_sample.sample <= round_src[out_width:1] + out_width'(round_src[0]);
    end
  end

  // counter must wrap before reaching the selected factor
  a_cnt_below_factor : assert property (
    @(posedge clock) disable iff (rst_all)
    int'(sample_cnt) < dec_factor(dec_sel)
  ) else $error("varcic sample counter reached factor");

endmodule

//--- design/cic_comb.sv
// Single CIC comb stage, differences its input against the value from the previous strobe
`timescale 1ns/1ps

module cic_comb
  import cic_cfg_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_all,
  input  logic                        strobe,
  input  logic signed [acc_width-1:0] in_data,
  output logic signed [acc_width-1:0] out_data
);

  // one-deep delay line, value seen at the last strobe
  logic signed [acc_width-1:0] prev_data;

  // registered difference
  // both registers move only on the output-rate strobe
  always_ff @(posedge clock)
  begin
    if (rst_all)
    begin
      out_data  <= '0;
      prev_data <= '0;
    end
    else if (strobe)
    begin
      out_data  <= in_data - prev_data;
      prev_data <= in_data;
    end
  end

endmodule

//--- design/cic_integrator.sv
// Single CIC integrator stage, accumulates its input on each strobe; chained inside varcic
`timescale 1ns/1ps

module cic_integrator
  import cic_cfg_pkg::*;
(
  input  logic                        clock,
  input  logic                        rst_all,
  input  logic                        strobe,
  input  logic signed [acc_width-1:0] in_data,
  output logic signed [acc_width-1:0] out_data
);

  // accumulator is the stage output
  // wraps at acc_width, which is fine for CIC arithmetic
  always_ff @(posedge clock)
  begin
    if (rst_all)
    begin
      out_data <= '0;
    end
    else if (strobe)
    begin
      out_data <= out_data + in_data;
    end
  end

endmodule

//--- design/rx_types_pkg.sv
// Receiver sample and output word structs plus the channel count, shared by receiver RTL and testbench
package rx_types_pkg;

  import cic_cfg_pkg::*;

  // --------------------------------------------------------------------------
  // channel numbering
  // --------------------------------------------------------------------------

  // two independent decimators
  localparam int num_chan = 2;
  localparam int chan_width = $clog2(num_chan);

  // channel index carried with every output word
  typedef logic [chan_width-1:0] chan_t;

  // --------------------------------------------------------------------------
  // stream payloads
  // --------------------------------------------------------------------------

  // one decimated sample, decimator to arbiter
  typedef struct packed {
    logic signed [out_width-1:0] sample;
  } dec_sample_t;

  // merged output bus word
  // chan sits above the sample
  typedef struct packed {
    chan_t                       chan;
    logic signed [out_width-1:0] sample;
  } rx_word_t;

endpackage

//--- design/cic_cfg_pkg.sv
// CIC decimator sizes plus the rate, growth and rounding helpers shared by the CIC RTL
package cic_cfg_pkg;

  // --------------------------------------------------------------------------
  // filter dimensions
  // --------------------------------------------------------------------------

  // integrator/comb pairs
  localparam int cic_stages = 5;
  // adc sample width
  localparam int in_width = 18;
  // 18 bits in plus up to 20 bits growth, with spare headroom
  localparam int acc_width = 45;
  // decimated sample width
  localparam int out_width = 18;

  // largest factor of the power-of-two family
  localparam int max_factor = 16;
  // input sample counter, counts 0 .. factor-1
  localparam int cnt_width = $clog2(max_factor);

  // --------------------------------------------------------------------------
  // rate selection
  // --------------------------------------------------------------------------

  // 0, 1, 2, 3 select decimation by 2, 4, 8, 16
  typedef logic [1:0] dec_code_t;

  // decimation factor for a code
  function automatic int dec_factor(dec_code_t code);
    return 2 << code;
  endfunction

  // bit growth, stages * log2(factor)
  function automatic int dec_growth(dec_code_t code);
    return cic_stages * (int'(code) + 1);
  endfunction

  // index of the rounding bit
  // the kept slice starts one above it
  function automatic int round_lsb(dec_code_t code);
    return in_width + dec_growth(code) - out_width - 1;
  endfunction

endpackage
